//--- dv/crc_crack_tests.txt
// one record per value: kind digit then four hex digits
// 1 = input byte, 2 = expected dout word, 3 = expected final status, F = end of list
// compare config 0x0001, salt '1', target cbf43926
10002 10003 10001 10000 10005 10000
10031 10026 10039 100F4 100CB 1004F
// word list 0x0010, "xyz" "23456789", second word matches
10002 10001 10010 10000 1000D 10000
10078 10079 1007A 10000
10032 10033 10034 10035 10036 10037 10038 10039 10000
10017
20201 20010 20001 2CBF4 23926
20202 20010 20002
// word list 0x0011, "ab" "q" "zz", no match
10002 10001 10011 10000 10008 10000
10061 10062 10000 10071 10000 1007A 1007A 10000
10028
20202 20011 20003
// compare config 0x0002, salt 'a', target 352441c2
10002 10003 10002 10000 10005 10000
10061 100C2 10041 10024 10035 100BD
// word list 0x0012, "23456789" then eight "bc", every "bc" matches
10002 10001 10012 10000 10021 10000
10032 10033 10034 10035 10036 10037 10038 10039 10000
10062 10063 10000 10062 10063 10000 10062 10063 10000 10062 10063 10000
10062 10063 10000 10062 10063 10000 10062 10063 10000 10062 10063 10000
100D4
20201 20012 20001 23524 241C2
20201 20012 20002 23524 241C2
20201 20012 20003 23524 241C2
20201 20012 20004 23524 241C2
20201 20012 20005 23524 241C2
20201 20012 20006 23524 241C2
20201 20012 20007 23524 241C2
20201 20012 20008 23524 241C2
20202 20012 20009
// compare config 0x0003 with a wrong checksum byte
10002 10003 10003 10000 10005 10000
10031 10026 10039 100F4 100CB 10000
30001
F0000

//--- dv/tb_crc_crack.sv
`timescale 1ns/10ps

module tb_crc_crack;

	// records the test file may hold, end record included
	localparam int TEST_DEPTH = 512;
	// timeout budget per record
	localparam int CYCLES_PER_RECORD = 40;
	// cycles after the error in which the output must stay empty
	localparam int QUIET_CYCLES = 20;

	logic CLK;
	logic arst_n;
	logic [7:0] din;
	logic wr_en;
	logic full;
	logic [15:0] dout;
	logic rd_en;
	logic empty;
	logic [7:0] pkt_comm_status;
	logic error;

	// raw records, kind in the top hex digit
	logic [19:0] tests [TEST_DEPTH];
	logic [7:0] in_bytes [$];
	logic [15:0] out_words [$];
	logic [7:0] exp_status;
	int n_records;
	int n_out;
	int out_idx = 0;
	int cycles = 0;
	int limit = 0;
	bit reset_done = 1'b0;
	bit driver_done = 1'b0;
	integer seed = 32'haa1e;

	crc_crack UUT (
		.CLK(CLK),
		.arst_n(arst_n),
		.din(din),
		.wr_en(wr_en),
		.full(full),
		.dout(dout),
		.rd_en(rd_en),
		.empty(empty),
		.pkt_comm_status(pkt_comm_status),
		.error(error)
	);

	// 100 ns clock
	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// ****************************************
	// failure reporting and compares
	// ****************************************
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_word(input logic [15:0] actual, input logic [15:0] expected,
		input int index);
		if (actual !== expected)
			abort_run($sformatf("Error dout (word %0d): got %h, expected %h",
				index, actual, expected));
	endtask

	task automatic check_status(input logic [7:0] actual, input logic [7:0] expected);
		if (actual !== expected)
			abort_run($sformatf("Error pkt_comm_status: got %h, expected %h",
				actual, expected));
	endtask

	// split the file into input bytes, output words and the final status
	task automatic load_tests();
		logic [3:0] kind;
		logic [15:0] value;
		bit found_end;
		bit found_status;
		found_end = 1'b0;
		found_status = 1'b0;
		$readmemh("dv/crc_crack_tests.txt", tests);
		for (int i = 0; i < TEST_DEPTH && !found_end; i++) begin
			kind = tests[i][19:16];
			value = tests[i][15:0];
			case (kind)
			4'h1: in_bytes.push_back(value[7:0]);
			4'h2: out_words.push_back(value);
			4'h3: begin
				exp_status = value[7:0];
				found_status = 1'b1;
			end
			4'hF: begin
				found_end = 1'b1;
				n_records = i;
			end
			default: abort_run($sformatf("record %0d of the test file has an unknown kind", i));
			endcase
		end
		if (!found_end)
			abort_run("the test file has no end record");
		else if (!found_status)
			abort_run("the test file has no expected status record");
	endtask

	// ****************************************
	// host write side
	// ****************************************
	// called just after a rising edge, returns just after the edge that took the byte
	task automatic send_byte(input logic [7:0] b);
		din = b;
		wr_en = 1'b1;
		// full only moves on clock edges, mid-cycle value holds to the next edge
		@(negedge CLK);
		while (full)
			@(negedge CLK);
		@(posedge CLK);
		#1;
	endtask

	initial begin : driver
		din = '0;
		wr_en = 1'b0;
		wait (reset_done);
		@(posedge CLK);
		#1;
		for (int i = 0; i < in_bytes.size(); i++)
			send_byte(in_bytes[i]);
		wr_en = 1'b0;
		din = '0;
		driver_done = 1'b1;
	end

	// ****************************************
	// host read side, random gaps
	// ****************************************
	initial begin : reader
		logic [31:0] rnd;
		rd_en = 1'b0;
		wait (reset_done);
		forever begin
			@(posedge CLK);
			#1;
			rnd = $random(seed);
			rd_en = rnd[0];
			// head word is stable mid-cycle, pop happens on the next edge
			@(negedge CLK);
			if (rd_en && !empty) begin
				if (out_idx >= out_words.size())
					abort_run($sformatf("output word %h arrived after the last expected one",
						dout));
				else begin
					check_word(dout, out_words[out_idx], out_idx);
					out_idx++;
				end
			end
		end
	end

	// cycle counter with a limit scaled to the test length
	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit)
			abort_run($sformatf("timeout after %0d cycles, the DUT stopped making progress",
				cycles));
	end

	initial begin
		arst_n = 1'b0;
		load_tests();
		n_out = out_words.size();
		limit = CYCLES_PER_RECORD * n_records;
		repeat (5) @(posedge CLK);
		#1;
		arst_n = 1'b1;
		reset_done = 1'b1;

		// all input taken and every expected word read back
		while (!(driver_done && out_idx == n_out))
			@(negedge CLK);

		// last packet carries a bad checksum
		while (!error)
			@(negedge CLK);
		check_status(pkt_comm_status, exp_status);
		if (!full)
			abort_run("full is low after the error, input is not blocked");

		// sticky error keeps input blocked and the output quiet
		repeat (QUIET_CYCLES) begin
			@(negedge CLK);
			if (!full)
				abort_run("full dropped after the error, input is no longer blocked");
			else if (!empty)
				abort_run("an output word appeared after the error");
		end

		$display("test passed");
		$finish;
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it, exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
	-f verilog.f \
	--top-module tb_crc_crack \
	-o sim_tb_crc_crack
./obj_dir/sim_tb_crc_crack

//--- verilog.f
verilog/pkt_comm_pkg.sv
verilog/crack_pkg.sv
verilog/inpkt_header.sv
verilog/word_list.sv
verilog/cmp_config.sv
verilog/crc_compare.sv
verilog/outpkt_builder.sv
verilog/crc_crack.sv
dv/tb_crc_crack.sv

//--- verilog/cmp_config.sv
`timescale 1ns/10ps

module cmp_config
	import crack_pkg::*;
(
	input logic CLK,
	input logic arst_n,
	input logic [7:0] din,
	input logic wr_en,
	input logic pkt_end,
	output logic [7:0] salt,
	output logic [31:0] target,
	output logic err_cmp_config
);

	// shadow copy, bytes in arrival order
	logic [7:0] shadow [CMP_CONFIG_LEN];
	logic [2:0] cnt;
	// more bytes than the config holds
	logic over;

	always_ff @(posedge CLK) begin
		if (wr_en && cnt < 3'(CMP_CONFIG_LEN))
			shadow[cnt] <= din;
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			over <= 1'b0;
			salt <= '0;
			target <= '0;
			err_cmp_config <= 1'b0;
		end else begin
			if (wr_en) begin
				if (cnt == 3'(CMP_CONFIG_LEN))
					over <= 1'b1;
				else
					cnt <= cnt + 3'd1;
			end
			if (pkt_end) begin
				// apply only a config of exactly the right size
				if (cnt == 3'(CMP_CONFIG_LEN) && !over) begin
					salt <= shadow[0];
					target <= {shadow[4], shadow[3], shadow[2], shadow[1]};
				end else
					err_cmp_config <= 1'b1;
				cnt <= '0;
				over <= 1'b0;
			end
		end
	end

endmodule

//--- verilog/crack_pkg.sv
package crack_pkg;

	// candidate words
	localparam int WORD_MAX_LEN = 8;
	localparam int WORD_LEN_BITS = 4;

	// ****************************************
	// CRC-32, reflected form
	// ****************************************
	localparam logic [31:0] CRC_POLY = 32'hEDB88320;
	localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;
	// final value is the register inverted
	localparam logic [31:0] CRC_XOR_OUT = 32'hFFFFFFFF;

	// compare config payload: salt, then target lsb first
	localparam int CMP_CONFIG_LEN = 5;

endpackage

//--- verilog/crc_compare.sv
`timescale 1ns/10ps

module crc_compare
	import crack_pkg::*;
(
	input logic CLK,
	input logic arst_n,
	input logic word_valid,
	input logic [63:0] word_bytes,
	input logic [3:0] word_len,
	input logic [15:0] word_id,
	input logic last_in_pkt,
	input logic [15:0] pkt_id,
	input logic [7:0] salt,
	input logic [31:0] target,
	input logic ready,
	output logic word_take,
	output logic match,
	output logic done,
	output logic [31:0] crc_out,
	output logic [15:0] res_pkt_id,
	output logic [15:0] res_word_id,
	output logic [15:0] num_processed,
	output logic busy
);

	typedef enum logic [1:0] {ST_IDLE, ST_SALT, ST_WORD, ST_DECIDE} state_t;
	state_t state;

	logic [31:0] crc;
	logic [63:0] bytes_r;
	logic [WORD_LEN_BITS-1:0] len_r;
	logic [2:0] idx;
	logic last_r;
	// words checked so far in the current packet
	logic [15:0] word_cnt;
	logic [31:0] crc_final;

	// one byte through the reflected CRC, lsb first
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++)
			r = (r >> 1) ^ (CRC_POLY & {32{r[0] ^ d[i]}});
		return r;
	endfunction

	assign busy = (state != ST_IDLE);
	assign word_take = word_valid && ready && state == ST_IDLE;
	assign crc_final = crc ^ CRC_XOR_OUT;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			crc <= CRC_INIT;
			idx <= '0;
			word_cnt <= '0;
			match <= 1'b0;
			done <= 1'b0;
		end else begin
			match <= 1'b0;
			done <= 1'b0;
			case (state)
			ST_IDLE: begin
				if (word_take) begin
					bytes_r <= word_bytes;
					len_r <= word_len;
					last_r <= last_in_pkt;
					res_pkt_id <= pkt_id;
					res_word_id <= word_id;
					crc <= CRC_INIT;
					state <= ST_SALT;
				end
			end
			ST_SALT: begin
				crc <= crc_byte(crc, salt);
				idx <= '0;
				state <= ST_WORD;
			end
			ST_WORD: begin
				crc <= crc_byte(crc, bytes_r[idx*8 +: 8]);
				idx <= idx + 3'd1;
				if ({1'b0, idx} == len_r - 1'b1)
					state <= ST_DECIDE;
			end
			default: begin
				crc_out <= crc_final;
				match <= (crc_final == target);
				done <= last_r;
				num_processed <= word_cnt + 16'd1;
				// count restarts with each word-list packet
				word_cnt <= last_r ? 16'd0 : word_cnt + 16'd1;
				state <= ST_IDLE;
			end
			endcase
		end
	end

	// a taken word always starts a check
	assert property (@(posedge CLK) disable iff (!arst_n)
		word_take |=> busy);

endmodule

//--- verilog/crc_crack.sv
`timescale 1ns/10ps

module crc_crack
	import pkt_comm_pkg::*;
(
	input logic CLK,
	input logic arst_n,
	input logic [7:0] din,
	input logic wr_en,
	output logic full,
	output logic [15:0] dout,
	input logic rd_en,
	output logic empty,
	output logic [7:0] pkt_comm_status,
	output logic error
);

	logic accept;
	logic [7:0] pkt_type;
	logic [15:0] pkt_id;
	logic pkt_data, pkt_end;
	logic err_version, err_type, err_len, err_checksum;
	logic is_word_list, is_cmp_config;
	logic word_full, word_valid, word_take, last_in_pkt, err_word_list;
	logic [63:0] word_bytes;
	logic [3:0] word_len;
	logic [15:0] word_id;
	logic [7:0] salt;
	logic [31:0] target;
	logic err_cmp_config;
	logic match, done, busy, ready;
	logic [31:0] crc_out;
	logic [15:0] res_pkt_id, res_word_id, num_processed;
	logic [7:0] status_w;

	// ****************************************
	// input dispatch
	// ****************************************
	assign accept = wr_en && !full;
	assign is_word_list = (pkt_type == PKT_TYPE_WORD_LIST);
	assign is_cmp_config = (pkt_type == PKT_TYPE_CMP_CONFIG);

	// hold config bytes while a check runs, salt must stay put
	assign full = error || word_full || (pkt_data && is_cmp_config && busy);

	inpkt_header inpkt_header (
		.CLK(CLK), .arst_n(arst_n), .din(din), .wr_en(accept),
		.pkt_type(pkt_type), .pkt_id(pkt_id), .pkt_data(pkt_data), .pkt_end(pkt_end),
		.err_version(err_version), .err_type(err_type),
		.err_len(err_len), .err_checksum(err_checksum)
	);

	word_list word_list (
		.CLK(CLK), .arst_n(arst_n), .din(din),
		.wr_en(accept && pkt_data && is_word_list),
		.pkt_end(pkt_end && is_word_list), .word_take(word_take),
		.word_full(word_full), .word_valid(word_valid), .word_bytes(word_bytes),
		.word_len(word_len), .word_id(word_id), .last_in_pkt(last_in_pkt),
		.err_word_list(err_word_list)
	);

	cmp_config cmp_config (
		.CLK(CLK), .arst_n(arst_n), .din(din),
		.wr_en(accept && pkt_data && is_cmp_config),
		.pkt_end(pkt_end && is_cmp_config),
		.salt(salt), .target(target), .err_cmp_config(err_cmp_config)
	);

	crc_compare crc_compare (
		.CLK(CLK), .arst_n(arst_n), .word_valid(word_valid), .word_bytes(word_bytes),
		.word_len(word_len), .word_id(word_id), .last_in_pkt(last_in_pkt),
		.pkt_id(pkt_id), .salt(salt), .target(target), .ready(ready),
		.word_take(word_take), .match(match), .done(done), .crc_out(crc_out),
		.res_pkt_id(res_pkt_id), .res_word_id(res_word_id),
		.num_processed(num_processed), .busy(busy)
	);

	outpkt_builder outpkt_builder (
		.CLK(CLK), .arst_n(arst_n), .match(match), .done(done), .crc_out(crc_out),
		.res_pkt_id(res_pkt_id), .res_word_id(res_word_id),
		.num_processed(num_processed), .rd_en(rd_en),
		.ready(ready), .dout(dout), .empty(empty)
	);

	// ****************************************
	// status and sticky error
	// ****************************************
	always_comb begin
		status_w = '0;
		status_w[ERR_CHECKSUM] = err_checksum;
		status_w[ERR_LEN] = err_len;
		status_w[ERR_TYPE] = err_type;
		status_w[ERR_VERSION] = err_version;
		status_w[ERR_WORD_LIST] = err_word_list;
		status_w[ERR_CMP_CONFIG] = err_cmp_config;
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			pkt_comm_status <= '0;
			error <= 1'b0;
		end else begin
			pkt_comm_status <= status_w;
			// once set, input stays blocked
			if (|status_w)
				error <= 1'b1;
		end
	end

endmodule

//--- verilog/inpkt_header.sv
`timescale 1ns/10ps

module inpkt_header
	import pkt_comm_pkg::*;
(
	input logic CLK,
	input logic arst_n,
	input logic [7:0] din,
	input logic wr_en,
	output logic [7:0] pkt_type,
	output logic [15:0] pkt_id,
	output logic pkt_data,
	output logic pkt_end,
	output logic err_version,
	output logic err_type,
	output logic err_len,
	output logic err_checksum
);

	typedef enum logic [1:0] {ST_HDR, ST_DATA, ST_CHK} state_t;
	state_t state;

	// position inside the header
	logic [2:0] hdr_cnt;
	logic [7:0] len_lo;
	// payload bytes still to come
	logic [15:0] data_left;
	// running 8-bit sum of the payload
	logic [7:0] sum;

	// classification is combinational, byte is tagged in the cycle it is taken
	assign pkt_data = (state == ST_DATA);
	assign pkt_end = wr_en && (state == ST_CHK);

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_HDR;
			hdr_cnt <= '0;
			len_lo <= '0;
			data_left <= '0;
			sum <= '0;
			pkt_type <= '0;
			pkt_id <= '0;
			err_version <= 1'b0;
			err_type <= 1'b0;
			err_len <= 1'b0;
			err_checksum <= 1'b0;
		end else if (wr_en) begin
			case (state)
			ST_HDR: begin
				hdr_cnt <= hdr_cnt + 3'd1;
				case (hdr_cnt)
				3'd0: begin
					if (din != PKT_VERSION)
						err_version <= 1'b1;
				end
				3'd1: begin
					pkt_type <= din;
					if (din != PKT_TYPE_WORD_LIST && din != PKT_TYPE_CMP_CONFIG)
						err_type <= 1'b1;
				end
				3'd2: pkt_id[7:0] <= din;
				3'd3: pkt_id[15:8] <= din;
				3'd4: len_lo <= din;
				default: begin
					// last header byte, length is complete
					data_left <= {din, len_lo};
					if ({din, len_lo} == 16'd0 || {din, len_lo} > PKT_MAX_LEN)
						err_len <= 1'b1;
					hdr_cnt <= '0;
					sum <= '0;
					state <= ST_DATA;
				end
				endcase
			end
			ST_DATA: begin
				sum <= sum + din;
				data_left <= data_left - 16'd1;
				if (data_left == 16'd1)
					state <= ST_CHK;
			end
			default: begin
				// trailing checksum byte
				if (din != sum)
					err_checksum <= 1'b1;
				state <= ST_HDR;
			end
			endcase
		end
	end

	// a byte is either payload or the closing checksum, never both
	assert property (@(posedge CLK) disable iff (!arst_n)
		pkt_end |-> !pkt_data);

endmodule

//--- verilog/outpkt_builder.sv
`timescale 1ns/10ps

module outpkt_builder
	import pkt_comm_pkg::*;
(
	input logic CLK,
	input logic arst_n,
	input logic match,
	input logic done,
	input logic [31:0] crc_out,
	input logic [15:0] res_pkt_id,
	input logic [15:0] res_word_id,
	input logic [15:0] num_processed,
	input logic rd_en,
	output logic ready,
	output logic [15:0] dout,
	output logic empty
);

	// ****************************************
	// record serializer
	// ****************************************
	logic active;
	// current record, 1 for done
	logic sel_done;
	logic [2:0] wcnt;
	// done record queued behind a match
	logic d_pend;
	logic [31:0] crc_r;
	logic [15:0] pkt_id_r, word_id_r, num_r;

	logic wr;
	logic [15:0] wr_data;
	logic last_word;

	always_comb begin
		wr = 1'b1;
		wr_data = '0;
		if (active && !sel_done) begin
			case (wcnt)
			3'd0: wr_data = {PKT_VERSION, OUTPKT_TYPE_MATCH};
			3'd1: wr_data = pkt_id_r;
			3'd2: wr_data = word_id_r;
			3'd3: wr_data = crc_r[31:16];
			default: wr_data = crc_r[15:0];
			endcase
		end else if (active) begin
			case (wcnt)
			3'd0: wr_data = {PKT_VERSION, OUTPKT_TYPE_DONE};
			3'd1: wr_data = pkt_id_r;
			default: wr_data = num_r;
			endcase
		end else if (match)
			// header word goes out in the pulse cycle
			wr_data = {PKT_VERSION, OUTPKT_TYPE_MATCH};
		else if (done)
			wr_data = {PKT_VERSION, OUTPKT_TYPE_DONE};
		else
			wr = 1'b0;
	end

	assign last_word = sel_done ? (wcnt == 3'(OUTPKT_DONE_WORDS - 1))
		: (wcnt == 3'(OUTPKT_MATCH_WORDS - 1));

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			sel_done <= 1'b0;
			wcnt <= '0;
			d_pend <= 1'b0;
		end else if (!active) begin
			if (match || done) begin
				active <= 1'b1;
				sel_done <= !match;
				d_pend <= match && done;
				wcnt <= 3'd1;
			end
		end else if (last_word) begin
			// match first, then a queued done
			if (!sel_done && d_pend) begin
				sel_done <= 1'b1;
				d_pend <= 1'b0;
				wcnt <= '0;
			end else
				active <= 1'b0;
		end else
			wcnt <= wcnt + 3'd1;
	end

	// result fields are held until the next pulse
	always_ff @(posedge CLK) begin
		if (match || done) begin
			crc_r <= crc_out;
			pkt_id_r <= res_pkt_id;
			word_id_r <= res_word_id;
			num_r <= num_processed;
		end
	end

	// ****************************************
	// 16-entry output FIFO, first-word fall-through
	// ****************************************
	logic [15:0] mem [16];
	logic [4:0] wptr, rptr;
	logic [4:0] used;

	assign used = wptr - rptr;
	assign empty = (used == 5'd0);
	assign dout = mem[rptr[3:0]];
	// room for a match and a done, nothing in flight here
	assign ready = (used <= 5'd8) && !active && !match && !done;

	always_ff @(posedge CLK) begin
		if (wr)
			mem[wptr[3:0]] <= wr_data;
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (wr)
				wptr <= wptr + 5'd1;
			if (rd_en && !empty)
				rptr <= rptr + 5'd1;
		end
	end

	assert property (@(posedge CLK) disable iff (!arst_n)
		wr |-> used != 5'd16);

endmodule

//--- verilog/pkt_comm_pkg.sv
package pkt_comm_pkg;

	// ****************************************
	// input packet format
	// ****************************************

	// version byte that every input packet must carry
	localparam logic [7:0] PKT_VERSION = 8'd2;

	// input packet types
	localparam logic [7:0] PKT_TYPE_WORD_LIST = 8'd1;
	localparam logic [7:0] PKT_TYPE_CMP_CONFIG = 8'd3;

	// version, type, id lo, id hi, len lo, len hi
	localparam int PKT_HEADER_LEN = 6;
	localparam logic [15:0] PKT_MAX_LEN = 16'd256;

	// ****************************************
	// output packet format
	// ****************************************
	localparam logic [7:0] OUTPKT_TYPE_MATCH = 8'd1;
	localparam logic [7:0] OUTPKT_TYPE_DONE = 8'd2;

	// length in 16-bit words, header word included
	localparam int OUTPKT_MATCH_WORDS = 5;
	localparam int OUTPKT_DONE_WORDS = 3;

	// bit positions in pkt_comm_status, bits 6 and 7 stay zero
	localparam int ERR_CHECKSUM = 0;
	localparam int ERR_LEN = 1;
	localparam int ERR_TYPE = 2;
	localparam int ERR_VERSION = 3;
	localparam int ERR_WORD_LIST = 4;
	localparam int ERR_CMP_CONFIG = 5;

endpackage

//--- verilog/word_list.sv
`timescale 1ns/10ps

module word_list
	import crack_pkg::*;
(
	input logic CLK,
	input logic arst_n,
	input logic [7:0] din,
	input logic wr_en,
	input logic pkt_end,
	input logic word_take,
	output logic word_full,
	output logic word_valid,
	output logic [63:0] word_bytes,
	output logic [3:0] word_len,
	output logic [15:0] word_id,
	output logic last_in_pkt,
	output logic err_word_list
);

	// word being assembled, first char in the low byte
	logic [63:0] buf_bytes;
	logic [WORD_LEN_BITS-1:0] buf_len;
	// closed word sits in the output regs, waiting to learn if it is last
	logic closed;
	logic [15:0] id_cnt;

	// input stalls while the closed word is offered and untaken
	assign word_full = word_valid;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			buf_len <= '0;
			closed <= 1'b0;
			id_cnt <= '0;
			word_valid <= 1'b0;
			last_in_pkt <= 1'b0;
			err_word_list <= 1'b0;
		end else begin
			if (word_take)
				word_valid <= 1'b0;

			if (wr_en && din == 8'd0) begin
				// terminator, empty word is an error
				if (buf_len == '0)
					err_word_list <= 1'b1;
				word_bytes <= buf_bytes;
				word_len <= buf_len;
				word_id <= id_cnt;
				id_cnt <= id_cnt + 16'd1;
				buf_len <= '0;
				closed <= 1'b1;
			end else if (wr_en) begin
				if (buf_len == WORD_LEN_BITS'(WORD_MAX_LEN))
					err_word_list <= 1'b1;
				else
					buf_len <= buf_len + 1'b1;
				buf_bytes[buf_len[2:0]*8 +: 8] <= din;
				// next char proves the closed word was not the last one
				if (closed) begin
					word_valid <= 1'b1;
					last_in_pkt <= 1'b0;
					closed <= 1'b0;
				end
			end

			if (pkt_end) begin
				// packet must end with a terminator
				if (!closed || buf_len != '0)
					err_word_list <= 1'b1;
				if (closed) begin
					word_valid <= 1'b1;
					last_in_pkt <= 1'b1;
				end
				closed <= 1'b0;
				buf_len <= '0;
				id_cnt <= '0;
			end
		end
	end

endmodule
